// ==== logic/issue_pkg.sv ====
// --------------------
// issue stage types
// --------------------
`default_nettype none

package issue_pkg;

    // byte distance from slot 0 to slot 1 in a fetch pair
    localparam logic [31:0] PC_STEP = 32'd4;

    // opcodes matched against inst[31:15]
    localparam logic [16:0] OPC_ADD_W   = 17'h00020;
    localparam logic [16:0] OPC_SUB_W   = 17'h00022;
    localparam logic [16:0] OPC_SYSCALL = 17'h00056;
    localparam logic [16:0] OPC_BREAK   = 17'h00054;

    // addi.w, matched against inst[31:22]
    localparam logic [9:0]  OPC_ADDI_W  = 10'h00a;

    // csr class, matched against inst[31:24]
    localparam logic [7:0]  OPC_CSR     = 8'h04;

    typedef enum logic [2:0] {
        OP_NOP     = 3'd0,
        OP_ADD     = 3'd1,
        OP_SUB     = 3'd2,
        OP_ADDI    = 3'd3,
        OP_SYSCALL = 3'd4,
        OP_BRK     = 3'd5,
        OP_CSR     = 3'd6
    } alu_op_t;

    // one decoded instruction
    typedef struct packed {
        logic [31:0] pc;
        alu_op_t     op;
        logic        is_alu;
        logic        is_syscall;
        logic        is_break;
        logic        is_priv;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        logic [31:0] imm;
    } uop_t;

    // instruction pair from fetch, inst1 lives at pc + 4
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst0;
        logic [31:0] inst1;
    } fetch_pair_t;

    // pair handed to register read
    typedef struct packed {
        uop_t slot0;
        uop_t slot1;
        logic valid0;
        logic valid1;
    } issue_pair_t;

endpackage

`default_nettype wire

// ==== logic/slot_decoder.sv ====
// --------------------
// single slot decoder
// --------------------
`default_nettype none
`timescale 1ns/1ps

module slot_decoder (
    input  logic [31:0]     inst,
    input  logic [31:0]     pc,
    output issue_pkg::uop_t uop
);

    logic [16:0] opc17;
    logic [9:0]  opc10;
    logic [7:0]  opc8;

    assign opc17 = inst[31:15];
    assign opc10 = inst[31:22];
    assign opc8  = inst[31:24];

    always_comb begin
        uop    = '0;
        uop.pc = pc;

        // register fields are taken from the word regardless of opcode
        uop.rd = inst[4:0];
        uop.rj = inst[9:5];
        uop.rk = inst[14:10];

        // the three opcode widths do not overlap, so order is free
        if (opc17 == issue_pkg::OPC_ADD_W) begin
            uop.op     = issue_pkg::OP_ADD;
            uop.is_alu = 1'b1;
        end else if (opc17 == issue_pkg::OPC_SUB_W) begin
            uop.op     = issue_pkg::OP_SUB;
            uop.is_alu = 1'b1;
        end else if (opc17 == issue_pkg::OPC_SYSCALL) begin
            uop.op         = issue_pkg::OP_SYSCALL;
            uop.is_syscall = 1'b1;
        end else if (opc17 == issue_pkg::OPC_BREAK) begin
            uop.op       = issue_pkg::OP_BRK;
            uop.is_break = 1'b1;
        end else if (opc10 == issue_pkg::OPC_ADDI_W) begin
            uop.op     = issue_pkg::OP_ADDI;
            uop.is_alu = 1'b1;
            // si12 immediate
            uop.imm    = {{20{inst[21]}}, inst[21:10]};
        end else if (opc8 == issue_pkg::OPC_CSR) begin
            uop.op      = issue_pkg::OP_CSR;
            uop.is_priv = 1'b1;
        end else begin
            // unknown word stays a nop with no class flag
            uop.op = issue_pkg::OP_NOP;
        end
    end

endmodule

`default_nettype wire

// ==== logic/pair_buffer.sv ====
// --------------------
// decode/issue register
// --------------------
`default_nettype none
`timescale 1ns/1ps

module pair_buffer (
    input  logic            clk,
    input  logic            rstn,
    input  logic            flush,

    input  logic            in_valid,
    output logic            in_allowin,
    input  issue_pkg::uop_t in_uop0,
    input  issue_pkg::uop_t in_uop1,

    output logic            out_valid,
    input  logic            out_allowin,
    output issue_pkg::uop_t out_uop0,
    output issue_pkg::uop_t out_uop1
);

    logic load;

    // an empty stage always takes a new pair
    assign in_allowin = out_allowin | ~out_valid;
    assign load       = in_allowin & in_valid;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            out_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0;
        end else if (in_allowin) begin
            out_valid <= in_valid;
        end
    end

    // payload only moves on an accepted transfer
    always_ff @(posedge clk) begin
        if (load) begin
            out_uop0 <= in_uop0;
            out_uop1 <= in_uop1;
        end
    end

endmodule

`default_nettype wire

// ==== logic/issue_splitter.sv ====
// --------------------
// dual issue splitter
// --------------------
`default_nettype none
`timescale 1ns/1ps

module issue_splitter (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   flush,

    input  logic                   buf_valid,
    output logic                   buf_allowin,
    input  issue_pkg::uop_t        buf_uop0,
    input  issue_pkg::uop_t        buf_uop1,

    output issue_pkg::issue_pair_t issue,
    output logic                   issue_valid,
    input  logic                   issue_allowin
);

    logic second_half;
    logic both_alu;
    logic raw_hazard;
    logic dual_ok;
    logic issue_fire;

    // slot 1 may not read what slot 0 writes in the same cycle
    assign both_alu   = buf_uop0.is_alu & buf_uop1.is_alu;
    assign raw_hazard = (buf_uop0.rd != 5'd0) &&
                        ((buf_uop0.rd == buf_uop1.rj) || (buf_uop0.rd == buf_uop1.rk));
    assign dual_ok    = both_alu & ~raw_hazard;

    assign issue_valid = buf_valid;
    assign issue_fire  = issue_valid & issue_allowin;

    // the buffer keeps a split pair until its second half leaves
    assign buf_allowin = issue_allowin & (second_half | dual_ok);

    // set after the first half of a split pair goes out
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            second_half <= 1'b0;
        end else if (flush) begin
            second_half <= 1'b0;
        end else if (issue_fire) begin
            if (second_half) begin
                second_half <= 1'b0;
            end else if (!dual_ok) begin
                second_half <= 1'b1;
            end
        end
    end

    always_comb begin
        issue        = '0;
        issue.valid0 = buf_valid;
        if (second_half) begin
            // buffered slot 1 moves down into slot 0
            issue.slot0  = buf_uop1;
            issue.valid1 = 1'b0;
        end else if (dual_ok) begin
            issue.slot0  = buf_uop0;
            issue.slot1  = buf_uop1;
            issue.valid1 = buf_valid;
        end else begin
            // first half of a split, slot 1 stays empty
            issue.slot0  = buf_uop0;
            issue.valid1 = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== logic/dual_issue_top.sv ====
// --------------------
// dual issue front end
// --------------------
`default_nettype none
`timescale 1ns/1ps

module dual_issue_top (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   flush,

    input  issue_pkg::fetch_pair_t fetch_pair,
    input  logic                   fetch_valid,
    output logic                   fetch_allowin,

    output issue_pkg::issue_pair_t issue,
    output logic                   issue_valid,
    input  logic                   issue_allowin
);

    logic [31:0]     pc1;
    issue_pkg::uop_t dec_uop0;
    issue_pkg::uop_t dec_uop1;
    issue_pkg::uop_t buf_uop0;
    issue_pkg::uop_t buf_uop1;
    logic            buf_valid;
    logic            buf_allowin;

    // second word of the pair sits one instruction later
    assign pc1 = fetch_pair.pc + issue_pkg::PC_STEP;

    slot_decoder slot_decoder0_inst (
        .inst (fetch_pair.inst0),
        .pc   (fetch_pair.pc),
        .uop  (dec_uop0)
    );

    slot_decoder slot_decoder1_inst (
        .inst (fetch_pair.inst1),
        .pc   (pc1),
        .uop  (dec_uop1)
    );

    pair_buffer pair_buffer_inst (
        .clk         (clk),
        .rstn        (rstn),
        .flush       (flush),
        .in_valid    (fetch_valid),
        .in_allowin  (fetch_allowin),
        .in_uop0     (dec_uop0),
        .in_uop1     (dec_uop1),
        .out_valid   (buf_valid),
        .out_allowin (buf_allowin),
        .out_uop0    (buf_uop0),
        .out_uop1    (buf_uop1)
    );

    issue_splitter issue_splitter_inst (
        .clk           (clk),
        .rstn          (rstn),
        .flush         (flush),
        .buf_valid     (buf_valid),
        .buf_allowin   (buf_allowin),
        .buf_uop0      (buf_uop0),
        .buf_uop1      (buf_uop1),
        .issue         (issue),
        .issue_valid   (issue_valid),
        .issue_allowin (issue_allowin)
    );

endmodule

`default_nettype wire

// ==== bench/dual_issue_assert.sv ====
// --------------------
// splitter checks
// --------------------
`default_nettype none
`timescale 1ns/1ps

module dual_issue_assert (
    input wire logic                   clk,
    input wire logic                   rstn,
    input wire logic                   flush,
    input wire logic                   buf_valid,
    input wire logic                   buf_allowin,
    input wire logic                   second_half,
    input wire issue_pkg::issue_pair_t issue,
    input wire logic                   issue_valid,
    input wire logic                   issue_allowin
);

    // a stalled issue must not change under the consumer
    stall_stable: assert property (@(posedge clk) disable iff (!rstn)
        (issue_valid && !issue_allowin && !flush) |=> (issue_valid && $stable(issue)))
        else $error("issue output changed while stalled");

    // second half only exists while the buffer still holds the pair
    no_slot1_in_second: assert property (@(posedge clk) disable iff (!rstn)
        second_half |-> (buf_valid && !issue.valid1))
        else $error("second half without buffered pair or with valid1 high");

    // first half of a split keeps the pair in the buffer
    hold_first_half: assert property (@(posedge clk) disable iff (!rstn)
        (issue_valid && !second_half && !issue.valid1) |-> !buf_allowin)
        else $error("buffer released during first half of split");

endmodule

bind issue_splitter dual_issue_assert dual_issue_assert_inst (
    .clk           (clk),
    .rstn          (rstn),
    .flush         (flush),
    .buf_valid     (buf_valid),
    .buf_allowin   (buf_allowin),
    .second_half   (second_half),
    .issue         (issue),
    .issue_valid   (issue_valid),
    .issue_allowin (issue_allowin)
);

`default_nettype wire

// ==== bench/dual_issue_tb.sv ====
// --------------------
// dual issue testbench
// --------------------
`default_nettype none
`timescale 1ns/1ps

module dual_issue_tb;

    logic                   clk;
    logic                   rstn;
    logic                   flush;
    issue_pkg::fetch_pair_t fetch_pair;
    logic                   fetch_valid;
    logic                   fetch_allowin;
    issue_pkg::issue_pair_t issue;
    logic                   issue_valid;
    logic                   issue_allowin;
    logic [15:0]            lfsr;
    int                     cycles;

    dual_issue_top dual_issue_top_inst (
        .clk           (clk),
        .rstn          (rstn),
        .flush         (flush),
        .fetch_pair    (fetch_pair),
        .fetch_valid   (fetch_valid),
        .fetch_allowin (fetch_allowin),
        .issue         (issue),
        .issue_valid   (issue_valid),
        .issue_allowin (issue_allowin)
    );

    always #5 clk = ~clk;

    // run limit, well above the length of all tests
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= 400) begin
            $display("run did not finish within 400 cycles");
            $display("SIMULATION FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic stop_run(input string msg);
        $display("FAILED at %0t: %s", $time, msg);
        $display("SIMULATION FAILED");
        $fatal(1, "check failed");
    endtask

    // taps 16,14,13,11
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [4:0] rand_reg();
        logic [31:0] r;
        r = rand_bits(5);
        return r[4:0] | 5'd1;
    endfunction

    function automatic issue_pkg::uop_t ref_decode(input logic [31:0] inst,
                                                   input logic [31:0] pc);
        issue_pkg::uop_t u;
        u    = '0;
        u.pc = pc;
        u.rd = inst[4:0];
        u.rj = inst[9:5];
        u.rk = inst[14:10];
        case (inst[31:15])
            17'h00020: begin
                u.op     = issue_pkg::OP_ADD;
                u.is_alu = 1'b1;
            end
            17'h00022: begin
                u.op     = issue_pkg::OP_SUB;
                u.is_alu = 1'b1;
            end
            17'h00056: begin
                u.op         = issue_pkg::OP_SYSCALL;
                u.is_syscall = 1'b1;
            end
            17'h00054: begin
                u.op       = issue_pkg::OP_BRK;
                u.is_break = 1'b1;
            end
            default: begin
                if (inst[31:22] == 10'h00a) begin
                    u.op     = issue_pkg::OP_ADDI;
                    u.is_alu = 1'b1;
                    u.imm    = {{20{inst[21]}}, inst[21:10]};
                end else if (inst[31:24] == 8'h04) begin
                    u.op      = issue_pkg::OP_CSR;
                    u.is_priv = 1'b1;
                end
            end
        endcase
        return u;
    endfunction

    function automatic logic [31:0] enc_rrr(input logic [16:0] opc, input logic [4:0] rd,
                                            input logic [4:0] rj, input logic [4:0] rk);
        return {opc, rk, rj, rd};
    endfunction

    function automatic logic [31:0] enc_addi(input logic [4:0] rd, input logic [4:0] rj,
                                             input logic [11:0] imm);
        return {10'h00a, imm, rj, rd};
    endfunction

    task automatic check_uop(input issue_pkg::uop_t exp, input issue_pkg::uop_t got,
                             input string what);
        if (got !== exp) begin
            stop_run($sformatf("%s expected %h got %h", what, exp, got));
        end
    endtask

    task automatic check_pair(input issue_pkg::issue_pair_t exp,
                              input issue_pkg::issue_pair_t got);
        if (got.valid0 !== exp.valid0 || got.valid1 !== exp.valid1) begin
            stop_run($sformatf("valid bits expected %b%b got %b%b",
                               exp.valid0, exp.valid1, got.valid0, got.valid1));
        end
        check_uop(exp.slot0, got.slot0, "slot0");
        if (exp.valid1) begin
            check_uop(exp.slot1, got.slot1, "slot1");
        end
    endtask

    task automatic check_bit(input logic exp, input logic got, input string what);
        if (got !== exp) begin
            stop_run($sformatf("%s expected %b got %b", what, exp, got));
        end
    endtask

    // returns one cycle after the accepting edge, at a falling edge
    task automatic send_pair(input logic [31:0] pc, input logic [31:0] i0,
                             input logic [31:0] i1);
        fetch_pair  = '{pc: pc, inst0: i0, inst1: i1};
        fetch_valid = 1'b1;
        #1;
        while (!fetch_allowin) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        fetch_valid = 1'b0;
    endtask

    task automatic expect_issue(input issue_pkg::issue_pair_t exp);
        while (!issue_valid) begin
            @(negedge clk);
        end
        check_pair(exp, issue);
        @(negedge clk);
    endtask

    // sends a pair and follows it through one or two issue transfers
    task automatic run_pair(input logic [31:0] pc, input logic [31:0] i0,
                            input logic [31:0] i1, input logic want_dual);
        issue_pkg::uop_t       u0;
        issue_pkg::uop_t       u1;
        issue_pkg::issue_pair_t exp;
        logic                  dual;
        u0   = ref_decode(i0, pc);
        u1   = ref_decode(i1, pc + 32'd4);
        dual = u0.is_alu && u1.is_alu &&
               (u0.rd == 5'd0 || (u0.rd != u1.rj && u0.rd != u1.rk));
        check_bit(want_dual, dual, "reference dual decision");
        send_pair(pc, i0, i1);
        check_bit(1'b1, issue_valid, "issue_valid one cycle after accept");
        exp = '0;
        exp.slot0  = u0;
        exp.valid0 = 1'b1;
        if (dual) begin
            exp.slot1  = u1;
            exp.valid1 = 1'b1;
            expect_issue(exp);
        end else begin
            expect_issue(exp);
            check_bit(1'b1, issue_valid, "second half issue_valid");
            exp.slot0 = u1;
            expect_issue(exp);
        end
        check_bit(1'b0, issue_valid, "issue_valid after last transfer");
    endtask

    task automatic test_independent();
        logic [4:0]  rd0;
        logic [31:0] imm;
        rd0 = rand_reg();
        imm = rand_bits(12);
        run_pair(32'h1c00_0000, enc_rrr(issue_pkg::OPC_ADD_W, rd0, rand_reg(), rand_reg()),
                 enc_addi(rand_reg(), rd0 + 5'd1, imm[11:0]), 1'b1);
    endtask

    task automatic test_dependent();
        logic [4:0] rd0;
        rd0 = rand_reg();
        run_pair(32'h1c00_0100, enc_rrr(issue_pkg::OPC_SUB_W, rd0, rand_reg(), rand_reg()),
                 enc_rrr(issue_pkg::OPC_ADD_W, rand_reg(), rd0, rd0 + 5'd3), 1'b0);
    endtask

    task automatic test_non_alu();
        run_pair(32'h1c00_0200, {issue_pkg::OPC_SYSCALL, 15'h0011},
                 {issue_pkg::OPC_BREAK, 15'h0002}, 1'b0);
        run_pair(32'h1c00_0300, {8'h04, 14'h0005, 5'd0, 5'd7},
                 enc_rrr(issue_pkg::OPC_ADD_W, 5'd4, 5'd5, 5'd6), 1'b0);
    endtask

    task automatic test_rd_cases();
        logic [4:0]  rd0;
        logic [31:0] imm;
        imm = rand_bits(12);
        // x0 destination never creates a hazard
        run_pair(32'h1c00_0400, enc_rrr(issue_pkg::OPC_ADD_W, 5'd0, rand_reg(), rand_reg()),
                 enc_addi(rand_reg(), 5'd0, imm[11:0]), 1'b1);
        rd0 = rand_reg();
        run_pair(32'h1c00_0500, enc_rrr(issue_pkg::OPC_ADD_W, rd0, rand_reg(), rand_reg()),
                 enc_rrr(issue_pkg::OPC_SUB_W, rand_reg(), rd0 + 5'd2, rd0), 1'b0);
    endtask

    task automatic test_backpressure();
        issue_pkg::issue_pair_t held;
        logic [31:0]            i0;
        logic [31:0]            i1;
        i0 = enc_rrr(issue_pkg::OPC_ADD_W, 5'd9, 5'd1, 5'd2);
        i1 = enc_rrr(issue_pkg::OPC_ADD_W, 5'd3, 5'd9, 5'd4);
        held = '0;
        held.slot0  = ref_decode(i0, 32'h1c00_0600);
        held.valid0 = 1'b1;
        send_pair(32'h1c00_0600, i0, i1);
        issue_allowin = 1'b0;
        check_bit(1'b1, issue_valid, "issue_valid under stall");
        check_pair(held, issue);
        repeat (4) begin
            @(negedge clk);
            check_pair(held, issue);
            check_bit(1'b0, fetch_allowin, "fetch_allowin under stall");
        end
        issue_allowin = 1'b1;
        expect_issue(held);
        held.slot0 = ref_decode(i1, 32'h1c00_0604);
        expect_issue(held);
        check_bit(1'b0, issue_valid, "issue_valid after split");
    endtask

    task automatic test_flush();
        issue_pkg::issue_pair_t exp;
        logic [31:0]            i0;
        logic [31:0]            i1;
        i0 = enc_rrr(issue_pkg::OPC_SUB_W, 5'd12, 5'd1, 5'd2);
        i1 = enc_rrr(issue_pkg::OPC_ADD_W, 5'd13, 5'd12, 5'd5);
        send_pair(32'h1c00_0700, i0, i1);
        exp = '0;
        exp.slot0  = ref_decode(i0, 32'h1c00_0700);
        exp.valid0 = 1'b1;
        expect_issue(exp);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        check_bit(1'b0, issue_valid, "issue_valid after flush");
        run_pair(32'h1c00_0800, i0, i1, 1'b0);
    endtask

    initial begin
        clk           = 1'b0;
        rstn          = 1'b0;
        flush         = 1'b0;
        fetch_pair    = '0;
        fetch_valid   = 1'b0;
        issue_allowin = 1'b1;
        cycles        = 0;
        lfsr          = 16'd34;
        repeat (2) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        check_bit(1'b0, issue_valid, "issue_valid after reset");
        test_independent();
        test_dependent();
        test_non_alu();
        test_rd_cases();
        test_backpressure();
        test_flush();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
logic/issue_pkg.sv
logic/slot_decoder.sv
logic/pair_buffer.sv
logic/issue_splitter.sv
logic/dual_issue_top.sv
bench/dual_issue_assert.sv
bench/dual_issue_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := dual_issue_tb
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)

SRCS := $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
